// ==== hdl/bias_src_pkg.sv ====
// bias source streamer package
`default_nettype none

package bias_src_pkg;

  localparam int unsigned ADDR_W = 32;  // byte address width
  localparam int unsigned CNT_W  = 16;  // transfer and beat counters, wrap at 2**CNT_W

  typedef logic [31:0] stream_data_t;  // output stream word
  typedef logic [63:0] mem_data_t;     // one word wider than the stream for misalignment
  typedef logic [1:0]  byte_off_t;     // byte offset within a 32-bit word

  // run control states
  typedef enum logic [1:0] {
    ST_IDLE,     // waiting for start
    ST_WORKING,  // addresses still being generated
    ST_DONE      // draining fifo and outstanding reads
  } streamer_state_e;

  // 2D strided pattern, captured on start
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;    // first byte address
    logic [CNT_W-1:0]  tot_len;      // total number of elements
    logic [CNT_W-1:0]  d0_len;       // inner length
    logic [ADDR_W-1:0] d0_stride;    // inner stride in bytes
    logic [ADDR_W-1:0] d1_stride;    // outer stride in bytes
    logic              ignore_bias;  // bias stream not used
  } pattern_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/addr_stream_if.sv ====
// address stream interface
`timescale 1ns/1ns
`default_nettype none

interface addr_stream_if
  import bias_src_pkg::*;
();

  logic              valid;  // address presented
  logic              ready;  // consumer can take it
  logic [ADDR_W-1:0] addr;   // biased byte address, may be unaligned
  logic              last;   // final address of the run

  // address generator side
  modport src (output valid, output addr, output last, input ready);

  // request side
  modport dst (input valid, input addr, input last, output ready);

endinterface

`default_nettype wire

// ==== hdl/strided_addr_gen.sv ====
// biased 2D strided address generator
`timescale 1ns/1ns
`default_nettype none

module strided_addr_gen
  import bias_src_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              start_i,       // run start, one cycle
  input  pattern_cfg_t      cfg_i,
  input  logic              bias_valid_i,
  input  logic [ADDR_W-1:0] bias_data_i,
  output logic              bias_ready_o,
  addr_stream_if.src        addr_o
);

  pattern_cfg_t      cfg_q;        // config held for the whole run
  logic              active_q;     // generating addresses
  logic [CNT_W-1:0]  elem_cnt_q;   // elements accepted so far
  logic [CNT_W-1:0]  inner_cnt_q;  // position in the inner dimension
  logic [ADDR_W-1:0] inner_off_q;  // inner_cnt * d0_stride
  logic [ADDR_W-1:0] outer_off_q;  // outer index * d1_stride
  logic [ADDR_W-1:0] bias;
  logic              bias_ok;
  logic              accept;
  logic              inner_wrap;

  assign bias_ok    = cfg_q.ignore_bias | bias_valid_i;  // need a bias word unless ignored
  assign bias       = cfg_q.ignore_bias ? '0 : bias_data_i;
  assign inner_wrap = (inner_cnt_q == cfg_q.d0_len - CNT_W'(1));  // end of inner row

  assign addr_o.valid = active_q & bias_ok;
  assign addr_o.addr  = cfg_q.base_addr + bias + inner_off_q + outer_off_q;
  assign addr_o.last  = (elem_cnt_q == cfg_q.tot_len - CNT_W'(1));  // tot_len 0 means full wrap
  assign accept       = addr_o.valid & addr_o.ready;

  // bias word consumed together with its address
  assign bias_ready_o = active_q & ~cfg_q.ignore_bias & addr_o.ready;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cfg_q <= cfg_i;  // sampled once per run
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      elem_cnt_q  <= '0;
      inner_cnt_q <= '0;
      inner_off_q <= '0;
      outer_off_q <= '0;
    end else if (clear_i) begin
      active_q    <= 1'b0;
      elem_cnt_q  <= '0;
      inner_cnt_q <= '0;
      inner_off_q <= '0;
      outer_off_q <= '0;
    end else if (start_i) begin
      active_q    <= 1'b1;  // first address next cycle
      elem_cnt_q  <= '0;
      inner_cnt_q <= '0;
      inner_off_q <= '0;
      outer_off_q <= '0;
    end else if (accept) begin
      elem_cnt_q <= elem_cnt_q + CNT_W'(1);
      if (addr_o.last) begin
        active_q <= 1'b0;  // quiet after the final address
      end
      if (inner_wrap) begin
        inner_cnt_q <= '0;
        inner_off_q <= '0;
        outer_off_q <= outer_off_q + cfg_q.d1_stride;  // step to next row
      end else begin
        inner_cnt_q <= inner_cnt_q + CNT_W'(1);
        inner_off_q <= inner_off_q + cfg_q.d0_stride;
      end
    end
  end

  // bias input must hold too, or the stalled address would move
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_o.valid && !addr_o.ready && !clear_i |=> $stable(addr_o.addr));

endmodule

`default_nettype wire

// ==== hdl/mem_read_issue.sv ====
// address fifo and memory read requests
`timescale 1ns/1ns
`default_nettype none

module mem_read_issue
  import bias_src_pkg::*;
#(
  parameter int unsigned ADDR_FIFO_DEPTH = 2
)
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,       // also pulsed on run start
  addr_stream_if.dst        addr_i,
  input  logic              stream_ready_i,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  input  logic              mem_gnt_i,
  output byte_off_t         off_o,         // byte offset of the granted entry
  output logic              issue_o,       // request taken this cycle
  output logic              fifo_empty_o,
  output logic              last_sent_o
);

  localparam int unsigned PTR_W = (ADDR_FIFO_DEPTH > 1) ? $clog2(ADDR_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_FW = $clog2(ADDR_FIFO_DEPTH + 1);

  logic [ADDR_W-1:0] fifo_q [ADDR_FIFO_DEPTH];  // address storage
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_FW-1:0] count_q;
  logic [ADDR_W-1:0] head;
  logic              push;
  logic              pop;
  logic              empty;

  assign empty        = (count_q == '0);
  assign addr_i.ready = (count_q != CNT_FW'(ADDR_FIFO_DEPTH));  // not full
  assign push         = addr_i.valid & addr_i.ready;
  assign head         = fifo_q[rd_ptr_q];

  assign mem_req_o    = ~empty & stream_ready_i;  // output back-pressure stalls requests
  assign pop          = mem_req_o & mem_gnt_i;
  assign mem_addr_o   = {head[ADDR_W-1:2], 2'b00};  // word aligned since 64-bit read covers rest
  assign off_o        = head[1:0];
  assign issue_o      = pop;
  assign fifo_empty_o = empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= addr_i.addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      last_sent_o <= 1'b0;
    end else if (clear_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      last_sent_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ADDR_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ADDR_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_FW'(1);
        2'b01:   count_q <= count_q - CNT_FW'(1);
        default: count_q <= count_q;  // both or neither
      endcase
      if (push && addr_i.last) begin
        last_sent_o <= 1'b1;  // generator finished
      end
    end
  end

  // a pending request and its address hold until grant unless the stream stalls
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_req_o && !mem_gnt_i |=> (mem_req_o && $stable(mem_addr_o)) || !stream_ready_i);

endmodule

`default_nettype wire

// ==== hdl/read_realign.sv ====
// offset fifo and read data realignment
`timescale 1ns/1ns
`default_nettype none

module read_realign
  import bias_src_pkg::*;
#(
  parameter int unsigned OFFSET_DEPTH = 8  // bounds reads in flight
)
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  byte_off_t    off_i,          // offset of the granted request
  input  logic         issue_i,        // request taken
  input  logic         mem_rvalid_i,
  input  mem_data_t    mem_rdata_i,
  input  logic         stream_ready_i,
  output logic         mem_rready_o,
  output logic         stream_valid_o,
  output stream_data_t stream_data_o
);

  localparam int unsigned PTR_W = (OFFSET_DEPTH > 1) ? $clog2(OFFSET_DEPTH) : 1;
  localparam int unsigned CNT_FW = $clog2(OFFSET_DEPTH + 1);

  byte_off_t         off_q [OFFSET_DEPTH];  // offsets in request order
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_FW-1:0] count_q;
  byte_off_t         head_off;
  mem_data_t         shifted;
  logic              pop;

  assign mem_rready_o   = stream_ready_i;  // memory holds data until the stream takes it
  assign stream_valid_o = mem_rvalid_i;    // no register stage
  assign head_off       = off_q[rd_ptr_q];

  // drop the leading bytes, the upper word supplies the spill-over
  assign shifted       = mem_rdata_i >> {head_off, 3'b000};
  assign stream_data_o = shifted[$bits(stream_data_t)-1:0];
  assign pop           = stream_valid_o & stream_ready_i;  // one offset per beat

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      off_q[wr_ptr_q] <= off_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (issue_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(OFFSET_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(OFFSET_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({issue_i, pop})
        2'b10:   count_q <= count_q + CNT_FW'(1);
        2'b01:   count_q <= count_q - CNT_FW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // too many reads in flight for the configured depth
  a_off_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    issue_i && !pop |-> count_q != CNT_FW'(OFFSET_DEPTH));

  // memory returned data that was never requested
  a_rvalid_empty: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_rvalid_i |-> count_q != '0);

endmodule

`default_nettype wire

// ==== hdl/streamer_ctrl.sv ====
// streamer run control
`timescale 1ns/1ns
`default_nettype none

module streamer_ctrl
  import bias_src_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic [CNT_W-1:0] tot_len_i,
  input  logic             last_sent_i,   // final address pushed to the fifo
  input  logic             fifo_empty_i,  // every address requested
  input  logic             beat_i,        // stream handshake
  output logic             ready_start_o,
  output logic             done_o,
  output logic             run_start_o
);

  streamer_state_e  cs;
  streamer_state_e  ns;
  logic [CNT_W-1:0] beat_cnt_q;  // beats sent this run

  always_comb begin
    ns            = cs;
    ready_start_o = 1'b0;
    done_o        = 1'b0;
    run_start_o   = 1'b0;
    case (cs)
      ST_IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) begin
          run_start_o = 1'b1;
          ns          = ST_WORKING;
        end
      end
      ST_WORKING: begin
        if (last_sent_i) ns = ST_DONE;  // address side finished
      end
      ST_DONE: begin
        if (fifo_empty_i && (beat_cnt_q == tot_len_i)) begin
          done_o = 1'b1;  // all beats out
          ns     = ST_IDLE;
        end
      end
      default: ns = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs         <= ST_IDLE;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      cs         <= ST_IDLE;
      beat_cnt_q <= '0;
    end else begin
      cs <= ns;
      if (done_o) beat_cnt_q <= '0;  // ready for the next run
      else if (beat_i) beat_cnt_q <= beat_cnt_q + CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bias_source_top.sv ====
// biased source streamer top
`timescale 1ns/1ns
`default_nettype none

module bias_source_top
  import bias_src_pkg::*;
#(
  parameter int unsigned OFFSET_DEPTH    = 8,  // >= reads in flight, grant to rvalid
  parameter int unsigned ADDR_FIFO_DEPTH = 2
)
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              start_i,
  input  pattern_cfg_t      cfg_i,
  output logic              ready_start_o,
  output logic              done_o,
  input  logic              bias_valid_i,
  output logic              bias_ready_o,
  input  logic [ADDR_W-1:0] bias_data_i,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  mem_data_t         mem_rdata_i,
  output logic              mem_rready_o,
  output logic              stream_valid_o,
  output stream_data_t      stream_data_o,
  input  logic              stream_ready_i
);

  logic      run_start;  // start accepted in idle
  logic      issue_clr;  // clear or new run
  logic      issue;
  byte_off_t off;
  logic      fifo_empty;
  logic      last_sent;
  logic      beat;

  addr_stream_if addr_if ();

  assign issue_clr = clear_i | run_start;
  assign beat      = stream_valid_o & stream_ready_i;

  strided_addr_gen i_addr_gen (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .start_i(run_start), .cfg_i(cfg_i),
    .bias_valid_i(bias_valid_i), .bias_data_i(bias_data_i), .bias_ready_o(bias_ready_o),
    .addr_o(addr_if.src)
  );

  mem_read_issue #(.ADDR_FIFO_DEPTH(ADDR_FIFO_DEPTH)) i_issue (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(issue_clr),
    .addr_i(addr_if.dst), .stream_ready_i(stream_ready_i),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_gnt_i(mem_gnt_i),
    .off_o(off), .issue_o(issue), .fifo_empty_o(fifo_empty), .last_sent_o(last_sent)
  );

  read_realign #(.OFFSET_DEPTH(OFFSET_DEPTH)) i_realign (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .off_i(off), .issue_i(issue),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i), .stream_ready_i(stream_ready_i),
    .mem_rready_o(mem_rready_o), .stream_valid_o(stream_valid_o), .stream_data_o(stream_data_o)
  );

  streamer_ctrl i_ctrl (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .start_i(start_i), .tot_len_i(cfg_i.tot_len),
    .last_sent_i(last_sent), .fifo_empty_i(fifo_empty), .beat_i(beat),
    .ready_start_o(ready_start_o), .done_o(done_o), .run_start_o(run_start)
  );

endmodule

`default_nettype wire

// ==== bench/tb_mem_model.sv ====
// scratchpad memory model
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model
  import bias_src_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,     // word aligned
  input  logic              gnt_rnd_i,  // grant for this cycle
  input  logic [1:0]        lat_rnd_i,  // extra latency, 0 to 3 cycles
  input  logic              rready_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output mem_data_t         rdata_o
);

  logic [ADDR_W-1:0] pend_addr [$];  // granted reads, oldest first
  int unsigned       pend_due  [$];  // first cycle each read may return
  int unsigned       cyc;

  assign gnt_o = gnt_rnd_i;

  // fill pattern over the whole address
  function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] p;
    p = a * 32'd7 + 32'd3;
    return p[7:0];
  endfunction

  // eight bytes from a, little-endian
  function automatic mem_data_t read_word(input logic [ADDR_W-1:0] a);
    mem_data_t w;
    for (int k = 0; k < 8; k++) begin
      w[8*k +: 8] = mem_byte(a + ADDR_W'(k));
    end
    return w;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_addr.delete();
      pend_due.delete();
      cyc = 0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      cyc = cyc + 1;
      if (rvalid_o && rready_i) begin  // head read taken
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      if (req_i && gnt_o) begin
        pend_addr.push_back(addr_i);
        pend_due.push_back(cyc + lat_rnd_i);  // zero extra means data next cycle
      end
      if (pend_addr.size() > 0) begin
        rvalid_o <= (pend_due[0] <= cyc);  // in order, head only
        rdata_o  <= read_word(pend_addr[0]);  // same head, so stable until taken
      end else begin
        rvalid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_bias_source.sv ====
// bias source streamer testbench
`timescale 1ns/1ns
`default_nettype none

module tb_bias_source
  import bias_src_pkg::*;
();

  localparam int unsigned MAX_ROWS = 8;

  logic              clk_i = 1'b0;
  logic              rst_ni, clear_i, start_i, ready_start_o, done_o, bias_ready_o;
  pattern_cfg_t      cfg_i;
  logic              bias_valid_i   = 1'b0;
  logic [ADDR_W-1:0] bias_data_i    = '0;
  logic              stream_ready_i = 1'b1;
  logic              gnt_rnd        = 1'b1;  // grant to the memory model
  logic [1:0]        lat_rnd        = 2'd0;  // extra read latency
  logic [ADDR_W-1:0] mem_addr_o;
  logic              mem_req_o, mem_gnt_i, mem_rvalid_i, mem_rready_o, stream_valid_o;
  mem_data_t         mem_rdata_i;
  stream_data_t      stream_data_o;

  string        row_name [MAX_ROWS];  // test table
  pattern_cfg_t row_cfg  [MAX_ROWS];
  bit           row_bp   [MAX_ROWS];  // random grant and stream back-pressure
  int unsigned  n_rows     = 0;
  int unsigned  cur_row    = 0;
  int unsigned  cur_len    = 0;
  bit           bias_on    = 1'b0;
  bit           bp_on      = 1'b0;
  logic [31:0]  lfsr_q     = 32'h1b74;
  logic [31:0]  bias_seen [$];  // accepted bias words in order
  int unsigned  beat_idx   = 0;
  int unsigned  done_cnt   = 0;
  int unsigned  data_errs  = 0;
  int unsigned  proto_errs = 0;
  int unsigned  run_errs   = 0;

  bias_source_top #(.OFFSET_DEPTH(8), .ADDR_FIFO_DEPTH(2)) uut (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i), .start_i(start_i), .cfg_i(cfg_i),
    .ready_start_o(ready_start_o), .done_o(done_o),
    .bias_valid_i(bias_valid_i), .bias_ready_o(bias_ready_o), .bias_data_i(bias_data_i),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_gnt_i(mem_gnt_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i), .mem_rready_o(mem_rready_o),
    .stream_valid_o(stream_valid_o), .stream_data_o(stream_data_o),
    .stream_ready_i(stream_ready_i)
  );

  tb_mem_model i_mem (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(mem_req_o), .addr_i(mem_addr_o),
    .gnt_rnd_i(gnt_rnd), .lat_rnd_i(lat_rnd), .rready_i(mem_rready_o),
    .gnt_o(mem_gnt_i), .rvalid_o(mem_rvalid_i), .rdata_o(mem_rdata_i)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};  // one step per bit
    end
    return v;
  endfunction

  function automatic logic [7:0] pattern_byte(input logic [31:0] a);
    logic [31:0] p;
    p = a * 32'd7 + 32'd3;
    return p[7:0];
  endfunction

  // four bytes from the element address
  function automatic logic [31:0] expected_word(input int unsigned idx);
    pattern_cfg_t c;
    int unsigned  d0;
    logic [31:0]  b;
    logic [31:0]  a;
    c  = row_cfg[cur_row];
    d0 = 32'(c.d0_len);
    b  = (!c.ignore_bias && int'(idx) < bias_seen.size()) ? bias_seen[idx] : 32'd0;
    a  = c.base_addr + b + (idx % d0) * c.d0_stride + (idx / d0) * c.d1_stride;
    return {pattern_byte(a + 32'd3), pattern_byte(a + 32'd2),
            pattern_byte(a + 32'd1), pattern_byte(a)};
  endfunction

  task automatic add_row(input string name, input logic [31:0] base, input int unsigned len,
                         input int unsigned d0, input logic [31:0] s0, input logic [31:0] s1,
                         input bit with_bias, input bit with_bp);
    pattern_cfg_t c;
    c.base_addr   = base;
    c.tot_len     = CNT_W'(len);
    c.d0_len      = CNT_W'(d0);
    c.d0_stride   = s0;
    c.d1_stride   = s1;
    c.ignore_bias = !with_bias;
    row_name[n_rows] = name;
    row_cfg[n_rows]  = c;
    row_bp[n_rows]   = with_bp;
    n_rows++;
  endtask

  // random bias, grant, latency and stream ready every cycle
  always @(posedge clk_i) begin
    if (start_i && ready_start_o) bias_seen.delete();  // new run
    if (bias_valid_i && bias_ready_o) bias_seen.push_back(bias_data_i);
    if (!bias_valid_i || bias_ready_o) begin  // a pending word holds until taken
      bias_data_i  <= rand_bits(32);
      bias_valid_i <= bias_on && (rand_bits(2) != 32'd0);  // gaps about one in four
    end
    gnt_rnd        <= bp_on ? (rand_bits(1) != 32'd0) : 1'b1;
    stream_ready_i <= bp_on ? (rand_bits(2) != 32'd0) : 1'b1;
    lat_rnd        <= 2'(rand_bits(2));
  end

  // output beat and done monitor
  always @(posedge clk_i) begin
    logic [31:0] exp_word;
    if (start_i && ready_start_o) begin
      beat_idx = 0;
      done_cnt = 0;
    end
    if (rst_ni && stream_valid_o && stream_ready_i) begin
      if (beat_idx >= cur_len) begin
        proto_errs++;
        $display("%s: output beat after all %0d beats were sent", row_name[cur_row], cur_len);
      end else begin
        exp_word = expected_word(beat_idx);
        if (stream_data_o !== exp_word) begin
          data_errs++;
          $display("ERR %s beat %0d: expected %08h, actual %08h", row_name[cur_row],
                   beat_idx, exp_word, stream_data_o);
        end
        beat_idx++;
      end
    end
    if (rst_ni && mem_rready_o !== stream_ready_i) begin
      proto_errs++;
      $display("ERR %s mem_rready_o: expected %0b, actual %0b", row_name[cur_row],
               stream_ready_i, mem_rready_o);
    end
    if (rst_ni && done_o) begin
      done_cnt++;
      if (beat_idx != cur_len) begin
        proto_errs++;
        $display("%s: done pulse after only %0d of %0d beats", row_name[cur_row],
                 beat_idx, cur_len);
      end
    end
  end

  initial begin
    rst_ni  <= 1'b0;
    clear_i <= 1'b0;
    start_i <= 1'b0;
    cfg_i   <= '0;
    add_row("contig_aligned", 32'h0000_0100, 16, 16, 32'd4, 32'd0, 1'b0, 1'b0);
    add_row("2d_unaligned", 32'h0000_0203, 24, 5, 32'd5, 32'd37, 1'b0, 1'b0);
    add_row("biased", 32'h0000_1000, 20, 4, 32'd4, 32'd64, 1'b1, 1'b0);
    add_row("bp_2d_unaligned", 32'h0000_03fe, 30, 7, 32'd3, 32'd100, 1'b0, 1'b1);
    add_row("bp_biased", 32'h0000_0081, 32, 8, 32'd6, 32'd50, 1'b1, 1'b1);
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (!ready_start_o || mem_req_o || stream_valid_o || done_o || bias_ready_o) begin
      run_errs++;
      $display("outputs not idle after reset");
    end
    for (int unsigned r = 0; r < n_rows; r++) begin
      cur_row = r;
      cur_len = 32'(row_cfg[r].tot_len);
      cfg_i   <= row_cfg[r];  // held for the whole run
      start_i <= 1'b1;
      bias_on <= !row_cfg[r].ignore_bias;
      bp_on   <= row_bp[r];
      @(posedge clk_i);
      start_i <= 1'b0;
      do @(posedge clk_i); while (!done_o);
      repeat (3) @(posedge clk_i);  // room for a stray beat or second done
      @(negedge clk_i);             // monitor counts settled
      if (done_cnt != 1) begin
        run_errs++;
        $display("ERR %s done pulses: expected 1, actual %0d", row_name[r], done_cnt);
      end
      if (beat_idx != cur_len) begin
        run_errs++;
        $display("ERR %s beats: expected %0d, actual %0d", row_name[r], cur_len, beat_idx);
      end
      if (!row_cfg[r].ignore_bias && bias_seen.size() != int'(cur_len)) begin
        run_errs++;
        $display("ERR %s bias words: expected %0d, actual %0d", row_name[r], cur_len,
                 bias_seen.size());
      end
      if (!ready_start_o) begin
        run_errs++;
        $display("%s: ready_start_o still low after done", row_name[r]);
      end
      @(posedge clk_i);
    end
    $display("errors: %0d data, %0d protocol, %0d run", data_errs, proto_errs, run_errs);
    if (data_errs == 0 && proto_errs == 0 && run_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog allows 40 cycles per element plus margin
  initial begin
    int unsigned limit;
    #1;
    limit = 1000;
    for (int unsigned r = 0; r < n_rows; r++) limit += 32'(row_cfg[r].tot_len) * 40;
    repeat (limit) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bias_source.f ====
hdl/bias_src_pkg.sv
hdl/addr_stream_if.sv
hdl/strided_addr_gen.sv
hdl/mem_read_issue.sv
hdl/read_realign.sv
hdl/streamer_ctrl.sv
hdl/bias_source_top.sv
bench/tb_mem_model.sv
bench/tb_bias_source.sv

// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_bias_source
FLIST  = bias_source.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)
